//--- Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_stage_pkg.sv
      - rtl/mem_stage_ctrl.sv
      - rtl/mem_req_build.sv
      - rtl/load_align.sv
      - rtl/wb_latch.sv
      - rtl/data_ram.sv
      - rtl/mem_stage_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/mem_stage_chk.sv
      - sim/mem_stage_tb.sv

//--- list.f
+incdir+rtl
rtl/mem_stage_pkg.sv
rtl/mem_stage_ctrl.sv
rtl/mem_req_build.sv
rtl/load_align.sv
rtl/wb_latch.sv
rtl/data_ram.sv
rtl/mem_stage_top.sv
sim/mem_stage_chk.sv
sim/mem_stage_tb.sv

//--- rtl/data_ram.sv
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module data_ram import mem_stage_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  mem_cmd_e             mem_cmd,
	input  logic [`MEM_XLEN-1:0] mem_addr,
	input  logic [`MEM_XLEN-1:0] mem_wdata,
	input  logic [`MEM_XLEN-1:0] mem_wmask,
	output logic                 mem_cmd_ready,
	output logic [`MEM_XLEN-1:0] mem_rdata,
	output logic                 mem_rdata_valid
);

	localparam int AW  = $clog2(`MEM_RAM_WORDS);
	localparam int GW  = $clog2(`MEM_RAM_GAP + 1);
	localparam int LAT = `MEM_RAM_LAT;

	logic [`MEM_XLEN-1:0] mem [`MEM_RAM_WORDS];
	logic [AW-1:0]        idx;
	logic [GW-1:0]        gap_cnt;
	logic [`MEM_XLEN-1:0] rd_pipe [LAT];
	logic [LAT-1:0]       vld_pipe;
	mem_word_u            old_w;
	mem_word_u            new_w;
	mem_word_u            msk_w;
	mem_word_u            mrg_w;

	assign idx   = mem_addr[AW+1:2]; // byte address to word index
	assign old_w = mem[idx];
	assign new_w = mem_wdata;
	assign msk_w = mem_wmask;

	always_comb begin
		for (int i = 0; i < `MEM_XLEN/8; i++)
			mrg_w.b[i] = (old_w.b[i] & ~msk_w.b[i]) | (new_w.b[i] & msk_w.b[i]);
	end

	always_ff @(posedge clk) begin
		if (mem_cmd == CMD_WRITE)
			mem[idx] <= mrg_w;
		if (mem_cmd == CMD_READ)
			rd_pipe[0] <= mem[idx];
		for (int i = 1; i < LAT; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gap_cnt  <= '0;
			vld_pipe <= '0;
		end else begin
			if (mem_cmd != CMD_NOP)
				gap_cnt <= GW'(`MEM_RAM_GAP);
			else if (gap_cnt != '0)
				gap_cnt <= gap_cnt - 1'b1;
			vld_pipe[0] <= (mem_cmd == CMD_READ);
			for (int i = 1; i < LAT; i++)
				vld_pipe[i] <= vld_pipe[i-1];
		end
	end

	assign mem_cmd_ready   = (gap_cnt == '0);
	assign mem_rdata       = rd_pipe[LAT-1];
	assign mem_rdata_valid = vld_pipe[LAT-1];

endmodule

//--- rtl/load_align.sv
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module load_align import mem_stage_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 load_done,
	input  mem_op_e              saved_op,
	input  logic [1:0]           lane,
	input  logic [`MEM_XLEN-1:0] mem_rdata,
	output logic [`MEM_XLEN-1:0] load_data
);

	mem_word_u            word;
	logic [7:0]           sel_b;
	logic [15:0]          sel_h;
	logic [`MEM_XLEN-1:0] ext;

	assign word  = mem_rdata;
	assign sel_b = word.b[lane];
	assign sel_h = word.h[lane[1]]; // halfword lane from bit 1

	always_comb begin
		case (saved_op)
			MEN_LB: begin
				ext = {{(`MEM_XLEN-8){sel_b[7]}}, sel_b};
			end
			MEN_LBU: begin
				ext = {{(`MEM_XLEN-8){1'b0}}, sel_b};
			end
			MEN_LH: begin
				ext = {{(`MEM_XLEN-16){sel_h[15]}}, sel_h};
			end
			MEN_LHU: begin
				ext = {{(`MEM_XLEN-16){1'b0}}, sel_h};
			end
			default: begin
				ext = word; // LW, whole word
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			load_data <= '0;
		else if (load_done)
			load_data <= ext;
	end

endmodule

//--- rtl/mem_req_build.sv
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module mem_req_build import mem_stage_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 issue,
	input  mem_op_e              saved_op,
	input  logic [`MEM_XLEN-1:0] saved_addr,
	input  logic [`MEM_XLEN-1:0] saved_rs2,
	output logic [`MEM_XLEN-1:0] mem_addr,
	output logic [`MEM_XLEN-1:0] mem_wdata,
	output logic [`MEM_XLEN-1:0] mem_wmask
);

	logic [1:0]           lane;
	logic [`MEM_XLEN-1:0] wdata_nxt;
	logic [`MEM_XLEN-1:0] wmask_nxt;

	assign lane = saved_addr[1:0];

	always_comb begin
		case (saved_op)
			MEN_SB: begin
				wdata_nxt = {(`MEM_XLEN/8){saved_rs2[7:0]}};
				wmask_nxt = {{(`MEM_XLEN-8){1'b0}}, 8'hff} << {lane, 3'b000};
			end
			MEN_SH: begin
				wdata_nxt = {(`MEM_XLEN/16){saved_rs2[15:0]}};
				wmask_nxt = {{(`MEM_XLEN-16){1'b0}}, 16'hffff} << {lane[1], 4'b0000};
			end
			MEN_SW: begin
				wdata_nxt = saved_rs2;
				wmask_nxt = '1;
			end
			default: begin
				wdata_nxt = saved_rs2;
				wmask_nxt = '0; // loads write nothing
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_addr  <= '0;
			mem_wmask <= '0;
		end else if (issue) begin
			mem_addr  <= {saved_addr[`MEM_XLEN-1:2], 2'b00}; // word aligned
			mem_wmask <= wmask_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			mem_wdata <= wdata_nxt;
	end

endmodule

//--- rtl/mem_stage_cfg.svh
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// data and address width of the stage
`define MEM_XLEN 32

// data RAM depth in words
`define MEM_RAM_WORDS 256

// cycles ready stays low after a command
`define MEM_RAM_GAP 2

// cycles from read command to valid pulse
`define MEM_RAM_LAT 3

`endif

//--- rtl/mem_stage_ctrl.sv
`timescale 1ns/100ps

module mem_stage_ctrl import mem_stage_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  mem_op_e  mem_wen,
	input  mem_op_e  saved_op,
	input  logic     mem_cmd_ready,
	input  logic     mem_rdata_valid,
	output logic     capture,
	output logic     pass,
	output logic     issue,
	output logic     publish,
	output logic     load_done,
	output mem_cmd_e mem_cmd,
	output logic     next_flg,
	output logic     is_stall
);

	typedef enum logic [1:0] {
		ST_WAIT,
		ST_WAIT_READY,
		ST_WAIT_VALID,
		ST_END
	} state_e;

	state_e state;
	state_e state_nxt;
	logic   is_store;

	assign is_store = (saved_op == MEN_SB) || (saved_op == MEN_SH) || (saved_op == MEN_SW);

	assign capture   = (state == ST_WAIT) && (mem_wen != MEN_X);
	assign pass      = (state == ST_WAIT) && (mem_wen == MEN_X);
	assign issue     = (state == ST_WAIT_READY) && mem_cmd_ready;
	assign load_done = (state == ST_WAIT_VALID) && mem_rdata_valid;
	assign publish   = (state == ST_END);

	assign next_flg = pass || publish; // input consumed at this edge
	assign is_stall = !next_flg;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_WAIT: begin
				if (capture)
					state_nxt = ST_WAIT_READY;
			end
			ST_WAIT_READY: begin
				if (issue)
					state_nxt = is_store ? ST_END : ST_WAIT_VALID;
			end
			ST_WAIT_VALID: begin
				if (load_done)
					state_nxt = ST_END;
			end
			default: begin
				state_nxt = ST_WAIT; // END always returns
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_WAIT;
			mem_cmd <= CMD_NOP;
		end else begin
			state <= state_nxt;
			if (issue)
				mem_cmd <= is_store ? CMD_WRITE : CMD_READ;
			else
				mem_cmd <= CMD_NOP; // single cycle strobe
		end
	end

endmodule

//--- rtl/mem_stage_pkg.sv
`include "mem_stage_cfg.svh"

package mem_stage_pkg;

	typedef enum logic [4:0] {
		MEN_X   = 5'd0, // no memory access
		MEN_SB  = 5'd1,
		MEN_SH  = 5'd2,
		MEN_SW  = 5'd3,
		MEN_LB  = 5'd4,
		MEN_LBU = 5'd5,
		MEN_LH  = 5'd6,
		MEN_LHU = 5'd7,
		MEN_LW  = 5'd8
	} mem_op_e;

	typedef enum logic [2:0] {
		CMD_NOP   = 3'd0,
		CMD_READ  = 3'd1,
		CMD_WRITE = 3'd2
	} mem_cmd_e;

	// only carried through this stage
	typedef enum logic [3:0] {
		WB_X   = 4'd0,
		WB_ALU = 4'd1,
		WB_MEM = 4'd2,
		WB_PC  = 4'd3,
		WB_CSR = 4'd4
	} wb_sel_e;

	// one data word, byte lanes or halfword lanes
	typedef union packed {
		logic [`MEM_XLEN/8-1:0][7:0]   b;
		logic [`MEM_XLEN/16-1:0][15:0] h;
	} mem_word_u;

endpackage

//--- rtl/mem_stage_top.sv
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module mem_stage_top (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [`MEM_XLEN-1:0]     reg_pc,
	input  logic [`MEM_XLEN-1:0]     rs2_data,
	input  logic [`MEM_XLEN-1:0]     alu_out,
	input  logic                     br_flg,
	input  logic [`MEM_XLEN-1:0]     br_target,
	input  mem_stage_pkg::mem_op_e   mem_wen,
	input  logic                     rf_wen,
	input  mem_stage_pkg::wb_sel_e   wb_sel,
	input  logic [4:0]               wb_addr,
	output logic [`MEM_XLEN-1:0]     out_read_data,
	output logic [`MEM_XLEN-1:0]     out_reg_pc,
	output logic [`MEM_XLEN-1:0]     out_alu_out,
	output logic                     out_br_flg,
	output logic [`MEM_XLEN-1:0]     out_br_target,
	output logic                     out_rf_wen,
	output mem_stage_pkg::wb_sel_e   out_wb_sel,
	output logic [4:0]               out_wb_addr,
	output logic                     next_flg,
	output logic                     is_stall
);

	mem_stage_pkg::mem_op_e  saved_op;
	mem_stage_pkg::mem_cmd_e mem_cmd;
	logic                    capture;
	logic                    pass;
	logic                    issue;
	logic                    publish;
	logic                    load_done;
	logic                    mem_cmd_ready;
	logic                    mem_rdata_valid;
	logic [`MEM_XLEN-1:0]    saved_addr;
	logic [`MEM_XLEN-1:0]    saved_rs2;
	logic [`MEM_XLEN-1:0]    mem_addr;
	logic [`MEM_XLEN-1:0]    mem_wdata;
	logic [`MEM_XLEN-1:0]    mem_wmask;
	logic [`MEM_XLEN-1:0]    mem_rdata;
	logic [`MEM_XLEN-1:0]    load_data;

	mem_stage_ctrl u_ctrl (
		.clk, .arst_n, .mem_wen, .saved_op, .mem_cmd_ready, .mem_rdata_valid,
		.capture, .pass, .issue, .publish, .load_done, .mem_cmd, .next_flg, .is_stall
	);

	wb_latch u_latch (
		.clk, .arst_n, .capture, .pass, .publish, .load_done, .load_data,
		.reg_pc, .rs2_data, .alu_out, .br_flg, .br_target, .mem_wen, .rf_wen,
		.wb_sel, .wb_addr, .saved_op, .saved_addr, .saved_rs2,
		.out_read_data, .out_reg_pc, .out_alu_out, .out_br_flg, .out_br_target,
		.out_rf_wen, .out_wb_sel, .out_wb_addr
	);

	mem_req_build u_req (
		.clk, .arst_n, .issue, .saved_op, .saved_addr, .saved_rs2,
		.mem_addr, .mem_wdata, .mem_wmask
	);

	load_align u_align (
		.clk, .arst_n, .load_done, .saved_op,
		.lane      (saved_addr[1:0]), // byte offset of the access
		.mem_rdata, .load_data
	);

	data_ram u_ram (
		.clk, .arst_n, .mem_cmd, .mem_addr, .mem_wdata, .mem_wmask,
		.mem_cmd_ready, .mem_rdata, .mem_rdata_valid
	);

endmodule

//--- rtl/wb_latch.sv
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module wb_latch import mem_stage_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 capture,
	input  logic                 pass,
	input  logic                 publish,
	input  logic                 load_done,
	input  logic [`MEM_XLEN-1:0] load_data,
	input  logic [`MEM_XLEN-1:0] reg_pc,
	input  logic [`MEM_XLEN-1:0] rs2_data,
	input  logic [`MEM_XLEN-1:0] alu_out,
	input  logic                 br_flg,
	input  logic [`MEM_XLEN-1:0] br_target,
	input  mem_op_e              mem_wen,
	input  logic                 rf_wen,
	input  wb_sel_e              wb_sel,
	input  logic [4:0]           wb_addr,
	output mem_op_e              saved_op,
	output logic [`MEM_XLEN-1:0] saved_addr,
	output logic [`MEM_XLEN-1:0] saved_rs2,
	output logic [`MEM_XLEN-1:0] out_read_data,
	output logic [`MEM_XLEN-1:0] out_reg_pc,
	output logic [`MEM_XLEN-1:0] out_alu_out,
	output logic                 out_br_flg,
	output logic [`MEM_XLEN-1:0] out_br_target,
	output logic                 out_rf_wen,
	output wb_sel_e              out_wb_sel,
	output logic [4:0]           out_wb_addr
);

	logic [`MEM_XLEN-1:0] saved_pc;
	logic                 saved_br_flg;
	logic [`MEM_XLEN-1:0] saved_br_target;
	logic                 saved_rf_wen;
	wb_sel_e              saved_wb_sel;
	logic [4:0]           saved_wb_addr;
	logic                 have_load; // aligner holds this access's data

	always_ff @(posedge clk) begin
		if (capture) begin
			saved_addr      <= alu_out;
			saved_rs2       <= rs2_data;
			saved_pc        <= reg_pc;
			saved_br_flg    <= br_flg;
			saved_br_target <= br_target;
			saved_rf_wen    <= rf_wen;
			saved_wb_sel    <= wb_sel;
			saved_wb_addr   <= wb_addr;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			saved_op      <= MEN_X;
			have_load     <= 1'b0;
			out_read_data <= '0;
			out_reg_pc    <= '0;
			out_alu_out   <= '0;
			out_br_flg    <= 1'b0;
			out_br_target <= '0;
			out_rf_wen    <= 1'b0;
			out_wb_sel    <= WB_X;
			out_wb_addr   <= '0;
		end else begin
			if (capture) begin
				saved_op  <= mem_wen;
				have_load <= 1'b0;
			end else if (load_done) begin
				have_load <= 1'b1;
			end
			if (pass) begin
				out_read_data <= '1;
				out_reg_pc    <= reg_pc;
				out_alu_out   <= alu_out;
				out_br_flg    <= br_flg;
				out_br_target <= br_target;
				out_rf_wen    <= rf_wen;
				out_wb_sel    <= wb_sel;
				out_wb_addr   <= wb_addr;
			end else if (publish) begin
				out_read_data <= have_load ? load_data : '1; // stores give all ones
				out_reg_pc    <= saved_pc;
				out_alu_out   <= saved_addr;
				out_br_flg    <= saved_br_flg;
				out_br_target <= saved_br_target;
				out_rf_wen    <= saved_rf_wen;
				out_wb_sel    <= saved_wb_sel;
				out_wb_addr   <= saved_wb_addr;
			end
		end
	end

endmodule

//--- sim/mem_stage_chk.sv
`timescale 1ns/100ps

module mem_stage_chk import mem_stage_pkg::*; (
	input logic     clk,
	input logic     arst_n,
	input mem_cmd_e mem_cmd,
	input logic     mem_cmd_ready,
	input logic     is_stall
);

	one_cycle_cmd: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_cmd != CMD_NOP) |=> (mem_cmd == CMD_NOP))
		else $error("memory command held for more than one cycle");

	// issue edge must have seen ready high
	cmd_when_ready: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_cmd != CMD_NOP) |-> $past(mem_cmd_ready))
		else $error("memory command issued while ready was low");

	// write ends at its command while read waits for data
	stall_at_cmd: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_cmd != CMD_NOP) |-> (is_stall == (mem_cmd == CMD_READ)))
		else $error("is_stall wrong in the cycle of a memory command");

	nop_in_reset: assert property (@(posedge clk)
		!arst_n |-> (mem_cmd == CMD_NOP))
		else $error("memory command not idle during reset");

endmodule

bind mem_stage_ctrl mem_stage_chk u_chk (
	.clk, .arst_n, .mem_cmd, .mem_cmd_ready, .is_stall
);

//--- sim/mem_stage_tb.sv
`timescale 1ns/100ps
`include "mem_stage_cfg.svh"

module mem_stage_tb import mem_stage_pkg::*; ();

	localparam int MAX_ENT    = 32;
	localparam int WAIT_LIMIT = 50; // cycles per access

	logic                 clk;
	logic                 arst_n;
	logic [`MEM_XLEN-1:0] reg_pc;
	logic [`MEM_XLEN-1:0] rs2_data;
	logic [`MEM_XLEN-1:0] alu_out;
	logic                 br_flg;
	logic [`MEM_XLEN-1:0] br_target;
	mem_op_e              mem_wen;
	logic                 rf_wen;
	wb_sel_e              wb_sel;
	logic [4:0]           wb_addr;
	logic [`MEM_XLEN-1:0] out_read_data;
	logic [`MEM_XLEN-1:0] out_reg_pc;
	logic [`MEM_XLEN-1:0] out_alu_out;
	logic                 out_br_flg;
	logic [`MEM_XLEN-1:0] out_br_target;
	logic                 out_rf_wen;
	wb_sel_e              out_wb_sel;
	logic [4:0]           out_wb_addr;
	logic                 next_flg;
	logic                 is_stall;

	// stimulus and expected values per entry
	mem_op_e              op_t   [MAX_ENT];
	logic [`MEM_XLEN-1:0] addr_t [MAX_ENT];
	logic [`MEM_XLEN-1:0] rs2_t  [MAX_ENT];
	logic [`MEM_XLEN-1:0] rd_t   [MAX_ENT];
	logic [`MEM_XLEN-1:0] pc_t   [MAX_ENT];
	logic [`MEM_XLEN-1:0] tgt_t  [MAX_ENT];
	logic                 br_t   [MAX_ENT];
	logic                 rf_t   [MAX_ENT];
	wb_sel_e              sel_t  [MAX_ENT];
	logic [4:0]           wba_t  [MAX_ENT];

	int          n_ent;
	int          errors;
	int          timeouts;
	int          cnt;
	int          i;
	logic        timed_out;
	logic [15:0] lfsr;

	mem_stage_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic take_bit();
		logic b;
		b    = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 16'hb400;
		return b;
	endfunction

	function automatic logic [`MEM_XLEN-1:0] rand_bits(input int n);
		logic [`MEM_XLEN-1:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
			v = {v[`MEM_XLEN-2:0], take_bit()};
		return v;
	endfunction

	task automatic add_entry(input mem_op_e op, input logic [`MEM_XLEN-1:0] addr, rs2, rd,
		input logic br, rf, input wb_sel_e sel);
		op_t[n_ent]   = op;
		addr_t[n_ent] = addr;
		rs2_t[n_ent]  = rs2;
		rd_t[n_ent]   = rd;
		br_t[n_ent]   = br;
		rf_t[n_ent]   = rf;
		sel_t[n_ent]  = sel;
		pc_t[n_ent]   = rand_bits(32);
		tgt_t[n_ent]  = rand_bits(32);
		wba_t[n_ent]  = 5'(rand_bits(5));
		n_ent++;
	endtask

	task automatic fill_table();
		add_entry(MEN_X,   32'h0000_1234, 32'h5555_aaaa, 32'hffff_ffff, 1'b1, 1'b1, WB_ALU);
		add_entry(MEN_SW,  32'h0000_0010, 32'h8765_4321, 32'hffff_ffff, 1'b0, 1'b0, WB_X);
		add_entry(MEN_LW,  32'h0000_0010, 32'h0000_0000, 32'h8765_4321, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_SW,  32'h0000_0020, 32'h0000_0000, 32'hffff_ffff, 1'b1, 1'b0, WB_X);
		add_entry(MEN_SB,  32'h0000_0021, 32'h0000_00a5, 32'hffff_ffff, 1'b0, 1'b0, WB_X);
		add_entry(MEN_SH,  32'h0000_0022, 32'hbeef_c3f0, 32'hffff_ffff, 1'b0, 1'b0, WB_CSR);
		add_entry(MEN_SB,  32'h0000_0020, 32'h1234_5677, 32'hffff_ffff, 1'b1, 1'b0, WB_X);
		add_entry(MEN_LW,  32'h0000_0020, 32'h0000_0000, 32'hc3f0_a577, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_X,   32'h0000_0abc, 32'h0f0f_0f0f, 32'hffff_ffff, 1'b1, 1'b0, WB_PC);
		add_entry(MEN_LB,  32'h0000_0021, 32'h0000_0000, 32'hffff_ffa5, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_LBU, 32'h0000_0021, 32'h0000_0000, 32'h0000_00a5, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_LB,  32'h0000_0020, 32'h0000_0000, 32'h0000_0077, 1'b1, 1'b1, WB_MEM);
		add_entry(MEN_LBU, 32'h0000_0023, 32'h0000_0000, 32'h0000_00c3, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_LB,  32'h0000_0023, 32'h0000_0000, 32'hffff_ffc3, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_LH,  32'h0000_0022, 32'h0000_0000, 32'hffff_c3f0, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_LHU, 32'h0000_0022, 32'h0000_0000, 32'h0000_c3f0, 1'b1, 1'b1, WB_MEM);
		add_entry(MEN_LH,  32'h0000_0020, 32'h0000_0000, 32'hffff_a577, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_LHU, 32'h0000_0020, 32'h0000_0000, 32'h0000_a577, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_SW,  32'h0000_0030, 32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0, WB_X);
		add_entry(MEN_SH,  32'h0000_0030, 32'habcd_1234, 32'hffff_ffff, 1'b1, 1'b0, WB_X);
		add_entry(MEN_SB,  32'h0000_0032, 32'h0000_0000, 32'hffff_ffff, 1'b0, 1'b0, WB_X);
		add_entry(MEN_LW,  32'h0000_0030, 32'h0000_0000, 32'hff00_1234, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_LH,  32'h0000_0030, 32'h0000_0000, 32'h0000_1234, 1'b1, 1'b1, WB_MEM);
		add_entry(MEN_LW,  32'h0000_0010, 32'h0000_0000, 32'h8765_4321, 1'b0, 1'b1, WB_MEM);
		add_entry(MEN_X,   32'h0000_0ffc, 32'h0000_0000, 32'hffff_ffff, 1'b0, 1'b1, WB_ALU);
	endtask

	task automatic check_word(input string name, input logic [`MEM_XLEN-1:0] got, exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_sel(input string name, input wb_sel_e got, exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_regnum(input string name, input logic [4:0] got, exp);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_reset();
		check_word("out_read_data", out_read_data, '0);
		check_word("out_reg_pc", out_reg_pc, '0);
		check_word("out_alu_out", out_alu_out, '0);
		check_word("out_br_target", out_br_target, '0);
		check_bit("out_br_flg", out_br_flg, 1'b0);
		check_bit("out_rf_wen", out_rf_wen, 1'b0);
		check_sel("out_wb_sel", out_wb_sel, WB_X);
		check_regnum("out_wb_addr", out_wb_addr, 5'd0);
		check_bit("is_stall", is_stall, 1'b0);
	endtask

	task automatic drive_entry(input int k);
		mem_wen   <= op_t[k];
		alu_out   <= addr_t[k];
		rs2_data  <= rs2_t[k];
		reg_pc    <= pc_t[k];
		br_target <= tgt_t[k];
		br_flg    <= br_t[k];
		rf_wen    <= rf_t[k];
		wb_sel    <= sel_t[k];
		wb_addr   <= wba_t[k];
	endtask

	task automatic check_outputs(input int k);
		check_word("out_read_data", out_read_data, rd_t[k]);
		check_word("out_reg_pc", out_reg_pc, pc_t[k]);
		check_word("out_alu_out", out_alu_out, addr_t[k]);
		check_word("out_br_target", out_br_target, tgt_t[k]);
		check_bit("out_br_flg", out_br_flg, br_t[k]);
		check_bit("out_rf_wen", out_rf_wen, rf_t[k]);
		check_sel("out_wb_sel", out_wb_sel, sel_t[k]);
		check_regnum("out_wb_addr", out_wb_addr, wba_t[k]);
	endtask

	// stall must hold until next_flg
	task automatic wait_next(input int k);
		cnt = 0;
		while (!next_flg && cnt < WAIT_LIMIT) begin
			check_bit("is_stall", is_stall, 1'b1);
			@(negedge clk);
			cnt++;
		end
		if (!next_flg) begin
			timeouts++;
			timed_out = 1'b1;
			$display("timeout at %0t: entry %0d never raised next_flg", $time, k);
		end
	endtask

	initial begin
		arst_n    = 1'b0;
		reg_pc    = '0;
		rs2_data  = '0;
		alu_out   = '0;
		br_flg    = 1'b0;
		br_target = '0;
		mem_wen   = MEN_X;
		rf_wen    = 1'b0;
		wb_sel    = WB_X;
		wb_addr   = '0;
		lfsr      = 16'd64607;
		n_ent     = 0;
		errors    = 0;
		timeouts  = 0;
		timed_out = 1'b0;
		fill_table();

		repeat (4) @(posedge clk);
		@(negedge clk);
		check_reset();
		@(posedge clk);
		arst_n <= 1'b1;

		@(posedge clk);
		drive_entry(0);
		@(negedge clk);
		for (i = 0; i < n_ent && !timed_out; i++) begin
			wait_next(i);
			if (!timed_out) begin
				if (op_t[i] == MEN_X && cnt != 0) begin
					errors++;
					$display("entry %0d is a pass-through but next_flg came late", i);
				end
				check_bit("is_stall", is_stall, 1'b0);
				@(posedge clk);
				if (i + 1 < n_ent)
					drive_entry(i + 1);
				else
					mem_wen <= MEN_X; // idle after the table
				@(negedge clk);
				check_outputs(i);
			end
		end

		$display("entries %0d, errors %0d, timeouts %0d", n_ent, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
